//--- design/simple_timer_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, register map and structs of the interval timer.
// Imported by every design module and by the testbench.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package simple_timer_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 12;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int COUNT_WIDTH = 64;

	typedef logic [ADDR_WIDTH-1:0] axi_addr_t;
	typedef logic [DATA_WIDTH-1:0] axi_data_t;
	typedef logic [STRB_WIDTH-1:0] axi_strb_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [COUNT_WIDTH-1:0] count_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// Byte offsets of the register map
	localparam axi_addr_t REG_CTRL = 12'h000;
	localparam axi_addr_t REG_STATUS = 12'h004;
	localparam axi_addr_t REG_MAX_LO = 12'h008;
	localparam axi_addr_t REG_MAX_HI = 12'h00c;
	localparam axi_addr_t REG_COUNT_LO = 12'h010;
	localparam axi_addr_t REG_COUNT_HI = 12'h014;
	localparam axi_addr_t REG_LAST = 12'h014;

	// Bit positions inside REG_CTRL
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_SRST_BIT = 1;

	typedef struct packed {
		logic enable;
		logic srst;
		count_t max_count;
	} timer_ctrl_t;

	typedef struct packed {
		logic running;
		count_t current_count;
	} timer_stat_t;

endpackage

//--- design/axi4_lite_slave_rw.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave that turns bus transfers into one-cycle register strobes.
// One transaction per channel in flight, responses held until accepted.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module axi4_lite_slave_rw (
	input logic clk,
	input logic rst_n,

	// Write address channel
	input simple_timer_pkg::axi_addr_t s_axi_awaddr,
	input logic [2:0] s_axi_awprot,
	input logic s_axi_awvalid,
	output logic s_axi_awready,

	// Write data channel
	input simple_timer_pkg::axi_data_t s_axi_wdata,
	input simple_timer_pkg::axi_strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,

	// Write response channel
	output simple_timer_pkg::axi_resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,

	// Read address channel
	input simple_timer_pkg::axi_addr_t s_axi_araddr,
	input logic [2:0] s_axi_arprot,
	input logic s_axi_arvalid,
	output logic s_axi_arready,

	// Read data channel
	output simple_timer_pkg::axi_data_t s_axi_rdata,
	output simple_timer_pkg::axi_resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	// Register write strobe
	output logic write_req,
	output simple_timer_pkg::axi_addr_t write_addr,
	output simple_timer_pkg::axi_data_t write_data,
	output simple_timer_pkg::axi_strb_t write_strb,
	input logic write_ok,

	// Register read strobe
	output logic read_req,
	output simple_timer_pkg::axi_addr_t read_addr,
	input logic read_ok,
	input simple_timer_pkg::axi_data_t read_value
);
	import simple_timer_pkg::*;

	typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
	typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic ready_en;

	// Keeps every ready low until the first edge out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_en <= 1'b0;
		end else begin
			ready_en <= 1'b1;
		end
	end

	// Address and data are taken together in one beat
	// Protection bits are accepted and not checked
	assign s_axi_awready = ready_en && wr_state == WR_IDLE && s_axi_awvalid && s_axi_wvalid;
	assign s_axi_wready = s_axi_awready;
	assign s_axi_bvalid = wr_state == WR_RESP;

	assign write_req = s_axi_awready;
	assign write_addr = s_axi_awaddr;
	assign write_data = s_axi_wdata;
	assign write_strb = s_axi_wstrb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: if (write_req) wr_state <= WR_RESP;
				WR_RESP: if (s_axi_bready) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (write_req) begin
			s_axi_bresp <= write_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Read side, arready drops while a response waits
	assign s_axi_arready = ready_en && rd_state == RD_IDLE;
	assign s_axi_rvalid = rd_state == RD_RESP;

	assign read_req = s_axi_arvalid && s_axi_arready;
	assign read_addr = s_axi_araddr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: if (read_req) rd_state <= RD_RESP;
				RD_RESP: if (s_axi_rready) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (read_req) begin
			s_axi_rdata <= read_value;
			s_axi_rresp <= read_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp));

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_rvalid && !s_axi_rready |=>
			s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp));

	// A strobe is never followed by another one on the next cycle
	a_strobe_gap: assert property (@(posedge clk) disable iff (!rst_n)
		(write_req |=> !write_req) and (read_req |=> !read_req));

endmodule

//--- design/simple_timer_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer register block fed by the slave strobes, drives the counter controls.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module simple_timer_regs (
	input logic clk,
	input logic rst_n,

	input logic write_req,
	input simple_timer_pkg::axi_addr_t write_addr,
	input simple_timer_pkg::axi_data_t write_data,
	input simple_timer_pkg::axi_strb_t write_strb,
	output logic write_ok,

	input logic read_req,
	input simple_timer_pkg::axi_addr_t read_addr,
	output logic read_ok,
	output simple_timer_pkg::axi_data_t read_value,

	output simple_timer_pkg::timer_ctrl_t ctrl,
	input simple_timer_pkg::timer_stat_t stat
);
	import simple_timer_pkg::*;

	logic enable;
	logic srst;
	logic srst_next;
	logic ctrl_write;
	count_t max_count;
	axi_data_t write_mask;
	axi_data_t ctrl_value;
	axi_data_t ctrl_merged;

	function automatic axi_data_t merge(axi_data_t old_value, axi_data_t new_value,
			axi_data_t mask);
		return (new_value & mask) | (old_value & ~mask);
	endfunction

	// One mask bit per data bit from the byte strobes
	always_comb begin
		for (int i = 0; i < DATA_WIDTH; i++) begin
			write_mask[i] = write_strb[i / 8];
		end
	end

	always_comb begin
		ctrl_value = '0;
		ctrl_value[CTRL_ENABLE_BIT] = enable;
		ctrl_value[CTRL_SRST_BIT] = srst;
	end

	assign ctrl_write = write_req && write_addr == REG_CTRL;
	assign ctrl_merged = merge(ctrl_value, write_data, write_mask);
	assign srst_next = ctrl_write ? ctrl_merged[CTRL_SRST_BIT] : srst;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable <= 1'b0;
			srst <= 1'b0;
			max_count <= '0;
		end else begin
			srst <= srst_next;
			// While srst is set, or being set, everything else stays cleared
			if (srst || srst_next) begin
				enable <= 1'b0;
				max_count <= '0;
			end else if (write_req) begin
				case (write_addr)
					REG_CTRL: enable <= ctrl_merged[CTRL_ENABLE_BIT];
					REG_MAX_LO: max_count[DATA_WIDTH-1:0] <=
						merge(max_count[DATA_WIDTH-1:0], write_data, write_mask);
					REG_MAX_HI: max_count[COUNT_WIDTH-1:DATA_WIDTH] <=
						merge(max_count[COUNT_WIDTH-1:DATA_WIDTH], write_data, write_mask);
					default: ;
				endcase
			end
		end
	end

	assign ctrl.enable = enable;
	assign ctrl.srst = srst;
	assign ctrl.max_count = max_count;

	// Every offset answers OKAY, unmapped ones read as zero
	assign write_ok = 1'b1;
	assign read_ok = 1'b1;

	always_comb begin
		read_value = '0;
		if (read_req && read_addr <= REG_LAST) begin
			case (read_addr)
				REG_CTRL: read_value = ctrl_value;
				REG_STATUS: read_value = axi_data_t'(stat.running);
				REG_MAX_LO: read_value = max_count[DATA_WIDTH-1:0];
				REG_MAX_HI: read_value = max_count[COUNT_WIDTH-1:DATA_WIDTH];
				REG_COUNT_LO: read_value = stat.current_count[DATA_WIDTH-1:0];
				REG_COUNT_HI: read_value = stat.current_count[COUNT_WIDTH-1:DATA_WIDTH];
				default: read_value = '0;
			endcase
		end
	end

	a_srst_clears: assert property (@(posedge clk) disable iff (!rst_n)
		srst |=> !enable && max_count == '0);

endmodule

//--- design/timer_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free-running interval counter, wraps at the limit and flags each expiry.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module timer_counter (
	input logic clk,
	input logic rst_n,

	input simple_timer_pkg::timer_ctrl_t ctrl,
	output simple_timer_pkg::timer_stat_t stat,

	output logic expired
);
	import simple_timer_pkg::*;

	count_t count;
	logic running;

	assign running = ctrl.enable && !ctrl.srst;

	// Wrap at or past the limit, so a lowered limit takes effect at once
	assign expired = running && count >= ctrl.max_count;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (ctrl.srst) begin
			count <= '0;
		end else if (expired) begin
			count <= '0;
		end else if (running) begin
			count <= count + 1'b1;
		end
	end

	assign stat.running = running;
	assign stat.current_count = count;

	// The value after a running cycle never passes the limit seen on that cycle
	a_count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		running |=> count <= $past(ctrl.max_count));

endmodule

//--- design/simple_timer_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interval timer top, AXI4-Lite register port plus the expiry pulse.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module simple_timer_top (
	input logic clk,
	input logic rst_n,

	input simple_timer_pkg::axi_addr_t s_axi_awaddr,
	input logic [2:0] s_axi_awprot,
	input logic s_axi_awvalid,
	output logic s_axi_awready,

	input simple_timer_pkg::axi_data_t s_axi_wdata,
	input simple_timer_pkg::axi_strb_t s_axi_wstrb,
	input logic s_axi_wvalid,
	output logic s_axi_wready,

	output simple_timer_pkg::axi_resp_t s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,

	input simple_timer_pkg::axi_addr_t s_axi_araddr,
	input logic [2:0] s_axi_arprot,
	input logic s_axi_arvalid,
	output logic s_axi_arready,

	output simple_timer_pkg::axi_data_t s_axi_rdata,
	output simple_timer_pkg::axi_resp_t s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	output logic expired
);
	import simple_timer_pkg::*;

	// Strobe interface between the slave and the registers
	logic write_req;
	axi_addr_t write_addr;
	axi_data_t write_data;
	axi_strb_t write_strb;
	logic write_ok;
	logic read_req;
	axi_addr_t read_addr;
	logic read_ok;
	axi_data_t read_value;

	timer_ctrl_t ctrl;
	timer_stat_t stat;

	axi4_lite_slave_rw i_slave (.*);

	simple_timer_regs i_regs (.*);

	timer_counter i_counter (.*);

endmodule

//--- bench/tb_axi_master.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite master tasks and the xorshift generator of the timer testbench.
// Included inside the testbench top, after its signals and compare tasks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [31:0] rng_state = 32'hbe427ff4;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	rng_state = x;
	return x;
endfunction

// Address and data are offered together
// Stall keeps bready low for that many cycles after bvalid
task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
		input int stall, output axi_resp_t resp);
	int waited;
	s_axi_awaddr = addr;
	s_axi_wdata = data;
	s_axi_wstrb = strb;
	s_axi_awvalid = 1'b1;
	s_axi_wvalid = 1'b1;
	waited = 0;
	@(negedge clk);
	while (!s_axi_awready) begin
		waited++;
		if (waited > WAIT_LIMIT) fail_run("timeout, write address and data never accepted");
		@(negedge clk);
	end
	if (!s_axi_wready) fail_run("wready stayed low while awready was high");
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_awvalid = 1'b0;
	s_axi_wvalid = 1'b0;
	waited = 0;
	@(negedge clk);
	while (!s_axi_bvalid) begin
		waited++;
		if (waited > WAIT_LIMIT) fail_run("timeout, no write response arrived");
		@(negedge clk);
	end
	resp = s_axi_bresp;
	repeat (stall) begin
		@(negedge clk);
		if (!s_axi_bvalid) fail_run("bvalid dropped before bready was given");
		check_resp(s_axi_bresp, resp, "s_axi_bresp");
	end
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_bready = 1'b1;
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_bready = 1'b0;
endtask

// Stall keeps rready low after rvalid and the payload must hold meanwhile
task automatic axi_read(input axi_addr_t addr, input int stall, output axi_data_t data,
		output axi_resp_t resp);
	int waited;
	s_axi_araddr = addr;
	s_axi_arvalid = 1'b1;
	waited = 0;
	@(negedge clk);
	while (!s_axi_arready) begin
		waited++;
		if (waited > WAIT_LIMIT) fail_run("timeout, read address never accepted");
		@(negedge clk);
	end
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_arvalid = 1'b0;
	waited = 0;
	@(negedge clk);
	while (!s_axi_rvalid) begin
		waited++;
		if (waited > WAIT_LIMIT) fail_run("timeout, no read data arrived");
		@(negedge clk);
	end
	data = s_axi_rdata;
	resp = s_axi_rresp;
	repeat (stall) begin
		@(negedge clk);
		if (!s_axi_rvalid) fail_run("rvalid dropped before rready was given");
		if (s_axi_arready) fail_run("arready high while a read response was pending");
		check_data(s_axi_rdata, data, "s_axi_rdata");
		check_resp(s_axi_rresp, resp, "s_axi_rresp");
	end
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_rready = 1'b1;
	@(posedge clk);
	#DRIVE_DELAY;
	s_axi_rready = 1'b0;
endtask

//--- bench/tb_simple_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench of the AXI4-Lite interval timer.
// Runs reset, strobe, expiry, hold, soft reset and back-pressure tests.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_simple_timer;
	import simple_timer_pkg::*;

	localparam int DRIVE_DELAY = 1;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic rst_n;
	axi_addr_t s_axi_awaddr;
	logic [2:0] s_axi_awprot;
	logic s_axi_awvalid;
	logic s_axi_awready;
	axi_data_t s_axi_wdata;
	axi_strb_t s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	axi_resp_t s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	axi_addr_t s_axi_araddr;
	logic [2:0] s_axi_arprot;
	logic s_axi_arvalid;
	logic s_axi_arready;
	axi_data_t s_axi_rdata;
	axi_resp_t s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic expired;

	// Expected contents of the limit halves
	axi_data_t max_lo_model;
	axi_data_t max_hi_model;

	simple_timer_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input axi_data_t actual, input axi_data_t expected,
			input string name);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_resp(input axi_resp_t actual, input axi_resp_t expected,
			input string name);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_count(input count_t actual, input count_t expected, input string name);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	`include "tb_axi_master.svh"

	// Byte lanes with a strobe take the new byte
	function automatic axi_data_t apply_strobes(axi_data_t old_word, axi_data_t new_word,
			axi_strb_t strb);
		axi_data_t result;
		result = old_word;
		for (int b = 0; b < STRB_WIDTH; b++) begin
			if (strb[b]) result[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return result;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic write_reg(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
		axi_resp_t resp;
		axi_write(addr, data, strb, 0, resp);
		check_resp(resp, RESP_OKAY, "s_axi_bresp");
	endtask

	task automatic read_reg(input axi_addr_t addr, output axi_data_t data);
		axi_resp_t resp;
		axi_read(addr, 0, data, resp);
		check_resp(resp, RESP_OKAY, "s_axi_rresp");
	endtask

	task automatic expect_reg(input axi_addr_t addr, input axi_data_t expected,
			input string name);
		axi_data_t data;
		read_reg(addr, data);
		check_data(data, expected, name);
	endtask

	// Counts falling edges up to the next edge that sees expired high
	task automatic wait_for_expiry(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) fail_run("timeout, no expired pulse seen");
		end while (!expired);
	endtask

	task automatic test_reset_state();
		expect_reg(REG_CTRL, '0, "REG_CTRL");
		expect_reg(REG_STATUS, '0, "REG_STATUS");
		expect_reg(REG_MAX_LO, '0, "REG_MAX_LO");
		expect_reg(REG_MAX_HI, '0, "REG_MAX_HI");
		expect_reg(REG_COUNT_LO, '0, "REG_COUNT_LO");
		expect_reg(REG_COUNT_HI, '0, "REG_COUNT_HI");
	endtask

	task automatic test_strobed_writes();
		axi_data_t word;
		axi_strb_t strb;
		for (int i = 0; i < 8; i++) begin
			word = xorshift32();
			strb = axi_strb_t'(xorshift32());
			if (i % 2 == 0) begin
				write_reg(REG_MAX_LO, word, strb);
				max_lo_model = apply_strobes(max_lo_model, word, strb);
			end else begin
				write_reg(REG_MAX_HI, word, strb);
				max_hi_model = apply_strobes(max_hi_model, word, strb);
			end
			expect_reg(REG_MAX_LO, max_lo_model, "REG_MAX_LO");
			expect_reg(REG_MAX_HI, max_hi_model, "REG_MAX_HI");
		end
	endtask

	task automatic test_expiry_period();
		int gap;
		axi_data_t limit;
		limit = xorshift32() % 13 + 3;
		write_reg(REG_MAX_HI, '0, '1);
		max_hi_model = '0;
		write_reg(REG_MAX_LO, limit, '1);
		max_lo_model = limit;
		write_reg(REG_CTRL, 32'h1, '1);
		// First call only lines up on a pulse
		wait_for_expiry(gap);
		wait_for_expiry(gap);
		check_count(count_t'(gap), count_t'(limit + 1), "expired period");
		next_cycle();
		expect_reg(REG_STATUS, 32'h1, "REG_STATUS");
	endtask

	task automatic test_hold_on_disable();
		axi_data_t first;
		axi_data_t second;
		write_reg(REG_CTRL, 32'h0, '1);
		expect_reg(REG_STATUS, '0, "REG_STATUS");
		read_reg(REG_COUNT_LO, first);
		read_reg(REG_COUNT_LO, second);
		check_data(second, first, "REG_COUNT_LO");
		if (first > max_lo_model) fail_run("count is above the limit after disable");
		expect_reg(REG_COUNT_HI, '0, "REG_COUNT_HI");
	endtask

	task automatic test_soft_reset();
		write_reg(REG_CTRL, 32'h1, '1);
		write_reg(REG_CTRL, 32'h3, 4'h1);
		expect_reg(REG_CTRL, 32'h2, "REG_CTRL");
		expect_reg(REG_MAX_LO, '0, "REG_MAX_LO");
		expect_reg(REG_MAX_HI, '0, "REG_MAX_HI");
		expect_reg(REG_COUNT_LO, '0, "REG_COUNT_LO");
		expect_reg(REG_COUNT_HI, '0, "REG_COUNT_HI");
		max_lo_model = '0;
		max_hi_model = '0;
		// Enable and limit writes are dropped while srst is set
		write_reg(REG_CTRL, 32'h3, '1);
		write_reg(REG_MAX_LO, 32'h5, '1);
		expect_reg(REG_CTRL, 32'h2, "REG_CTRL");
		expect_reg(REG_MAX_LO, '0, "REG_MAX_LO");
		write_reg(REG_CTRL, 32'h0, '1);
		expect_reg(REG_CTRL, '0, "REG_CTRL");
		write_reg(REG_MAX_LO, 32'h5, '1);
		max_lo_model = 32'h5;
		expect_reg(REG_MAX_LO, max_lo_model, "REG_MAX_LO");
		write_reg(REG_CTRL, 32'h1, '1);
		expect_reg(REG_STATUS, 32'h1, "REG_STATUS");
		write_reg(REG_CTRL, 32'h0, '1);
		expect_reg(REG_STATUS, '0, "REG_STATUS");
	endtask

	task automatic test_unmapped_and_stall();
		axi_data_t data;
		axi_data_t held_count;
		axi_resp_t resp;
		expect_reg(12'h018, '0, "unmapped 0x018");
		expect_reg(12'hffc, '0, "unmapped 0xffc");
		read_reg(REG_COUNT_LO, held_count);
		write_reg(12'h020, xorshift32(), '1);
		expect_reg(REG_CTRL, '0, "REG_CTRL");
		expect_reg(REG_MAX_LO, max_lo_model, "REG_MAX_LO");
		expect_reg(REG_MAX_HI, max_hi_model, "REG_MAX_HI");
		expect_reg(REG_COUNT_LO, held_count, "REG_COUNT_LO");
		expect_reg(12'h020, '0, "unmapped 0x020");
		data = xorshift32();
		axi_write(REG_MAX_LO, data, '1, 5, resp);
		check_resp(resp, RESP_OKAY, "s_axi_bresp");
		max_lo_model = data;
		axi_read(REG_MAX_LO, 5, data, resp);
		check_data(data, max_lo_model, "REG_MAX_LO");
		check_resp(resp, RESP_OKAY, "s_axi_rresp");
	endtask

	initial begin
		rst_n = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awprot = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arprot = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		max_lo_model = '0;
		max_hi_model = '0;
		repeat (3) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		test_reset_state();
		test_strobed_writes();
		test_expiry_period();
		test_hold_on_disable();
		test_soft_reset();
		test_unmapped_and_stall();
		$display("TEST PASS");
		$finish;
	end

endmodule

//--- simple_timer.f
+incdir+bench
design/simple_timer_pkg.sv
design/axi4_lite_slave_rw.sv
design/simple_timer_regs.sv
design/timer_counter.sv
design/simple_timer_top.sv
bench/tb_simple_timer.sv

//--- Makefile
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP := tb_simple_timer
FILE_LIST := simple_timer.f
BUILD_DIR := obj_dir
LOG := sim.log
PASS_TEXT := TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The exit status of the run is ignored, the log decides
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
